// ==== include/boot_defines.svh ====
`ifndef BOOT_DEFINES_SVH
`define BOOT_DEFINES_SVH

// Words copied from flash per boot
`define BOOT_WORDS 64
`define BOOT_BYTES (`BOOT_WORDS * 4)

// clk cycles per SCK half period
`define SCK_HALF 2

// Boot RAM word address width that holds BOOT_WORDS
`define RAM_AW 6

`define FLASH_READ_CMD 8'h03 // Single I/O read

`endif

// ==== hdl/boot_pkg.sv ====
`default_nettype none

`include "boot_defines.svh"

package boot_pkg;

   typedef logic [7:0]         byte_t;       // One SPI byte
   typedef logic [31:0]        word_t;       // One boot RAM word
   typedef logic [23:0]        flash_addr_t; // Flash byte address
   typedef logic [`RAM_AW-1:0] ram_addr_t;   // Boot RAM word address

   // Copier sequencing
   typedef enum logic [2:0] {
      IDLE,
      CMD,    // Opcode on MOSI
      ADDR,   // Three address bytes
      DATA,   // Read stream
      FINISH
   } boot_state_e;

endpackage

`default_nettype wire

// ==== hdl/sck_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "boot_defines.svh"

module sck_timer (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  run,
   output logic spi_sck,
   output logic fall_tick,
   output logic rise_tick,
   output logic byte_tick
);

   localparam int HW = (`SCK_HALF > 1) ? $clog2(`SCK_HALF) : 1;

   logic [HW-1:0] half_cnt;
   logic [2:0]    bit_cnt;  // Rising edges within the byte
   logic          sck_q;
   logic          half_end;

   assign half_end = (half_cnt == HW'(`SCK_HALF - 1));

   assign rise_tick = run && !sck_q && half_end;
   // Also pulls SCK low at once when run drops mid high phase
   assign fall_tick = sck_q && (half_end || !run);
   assign byte_tick = rise_tick && (bit_cnt == 3'd7);
   assign spi_sck   = sck_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         half_cnt <= '0;
         bit_cnt  <= '0;
         sck_q    <= 1'b0;
      end else begin
         if (!run || half_end)
            half_cnt <= '0;
         else
            half_cnt <= half_cnt + HW'(1);

         if (rise_tick)
            sck_q <= 1'b1;
         else if (fall_tick)
            sck_q <= 1'b0;

         if (!run)
            bit_cnt <= '0; // Each frame starts on a byte boundary
         else if (rise_tick)
            bit_cnt <= bit_cnt + 3'd1;
      end
   end

   a_ticks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(rise_tick && fall_tick));

endmodule

`default_nettype wire

// ==== hdl/spi_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_shifter import boot_pkg::*; (
   input  wire        clk,
   input  wire        rst_n,
   input  wire        load,
   input  wire byte_t tx_byte,
   input  wire        fall_tick,
   input  wire        rise_tick,
   input  wire        spi_miso,
   output logic       spi_mosi,
   output byte_t      rx_byte
);

   byte_t tx_sr;
   byte_t tx_hold;  // Next byte waiting for the falling edge
   byte_t rx_sr;
   logic  tx_pend;
   logic  defer;

   // A load on a byte boundary arrives with the 8th rise, so MOSI
   // must keep the last bit until SCK falls
   assign defer = rise_tick;

   assign spi_mosi = tx_sr[7]; // MSB first

   // Last bit bypasses the register so the byte is whole at byte_tick
   assign rx_byte = {rx_sr[6:0], spi_miso};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_sr   <= '0;
         tx_pend <= 1'b0;
      end else begin
         if (load && defer)
            tx_pend <= 1'b1;
         else if (fall_tick)
            tx_pend <= 1'b0;

         if (load && !defer)
            tx_sr <= tx_byte; // Opcode ahead of the first rise
         else if (fall_tick)
            tx_sr <= tx_pend ? tx_hold : {tx_sr[6:0], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         tx_hold <= tx_byte;
   end

   always_ff @(posedge clk) begin
      if (rise_tick)
         rx_sr <= {rx_sr[6:0], spi_miso};
   end

endmodule

`default_nettype wire

// ==== hdl/word_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "boot_defines.svh"

module word_assembler import boot_pkg::*; (
   input  wire        clk,
   input  wire        rst_n,
   input  wire        clear,
   input  wire        take,
   input  wire byte_t rx_byte,
   output logic       wr_en,
   output ram_addr_t  wr_addr,
   output word_t      wr_data
);

   logic [1:0]  lane;
   logic [23:0] low_lanes;    // Bytes 0 to 2 of the word in progress
   logic        last_written; // Top RAM word already written this boot

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lane    <= '0;
         wr_en   <= 1'b0;
         wr_addr <= '0;
      end else begin
         wr_en <= take && (lane == 2'd3);
         if (clear) begin
            lane    <= '0;
            wr_addr <= '0;
         end else begin
            if (take)
               lane <= lane + 2'd1;
            if (wr_en)
               wr_addr <= wr_addr + ram_addr_t'(1); // Next word after the write
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         last_written <= 1'b0;
      else if (clear)
         last_written <= 1'b0;
      else if (wr_en && (wr_addr == ram_addr_t'(`BOOT_WORDS - 1)))
         last_written <= 1'b1;
   end

   // First flash byte ends up in the lowest lane
   always_ff @(posedge clk) begin
      if (take) begin
         if (lane == 2'd3)
            wr_data <= {rx_byte, low_lanes};
         else
            low_lanes[lane*8 +: 8] <= rx_byte;
      end
   end

   a_write_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !last_written);

endmodule

`default_nettype wire

// ==== hdl/boot_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "boot_defines.svh"

module boot_ram import boot_pkg::*; (
   input  wire            clk,
   input  wire            wr_en,
   input  wire ram_addr_t wr_addr,
   input  wire word_t     wr_data,
   input  wire ram_addr_t rd_addr,
   output word_t          rd_data
);

   word_t mem [`BOOT_WORDS];

   // Copier side
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // Host side with one cycle latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== hdl/boot_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "boot_defines.svh"

module boot_fsm import boot_pkg::*; (
   input  wire          clk,
   input  wire          rst_n,
   input  wire          start,
   input  wire flash_addr_t flash_base,
   input  wire          byte_tick,
   output logic         run,
   output logic         spi_cs_n,
   output logic         load,
   output byte_t        tx_byte,
   output logic         take,
   output logic         clear,
   output logic         busy,
   output logic         done
);

   localparam int BW = `RAM_AW + 2; // Counts every data byte

   boot_state_e   state;
   flash_addr_t   base_q;
   logic [BW-1:0] byte_cnt;
   logic          accept;
   logic          last_byte;

   assign accept    = (state == IDLE) && start; // start ignored unless idle
   assign last_byte = (byte_cnt == BW'(`BOOT_BYTES - 1));

   // Opcode goes out at start and each address byte at the previous byte boundary
   assign load  = accept || (byte_tick && (state == CMD || state == ADDR));
   assign take  = byte_tick && (state == DATA);
   assign clear = accept;

   always_comb begin
      tx_byte = 8'h00; // Dummy byte and MOSI filler during DATA
      case (state)
         IDLE: tx_byte = `FLASH_READ_CMD;
         CMD:  tx_byte = base_q[23:16];
         ADDR: begin
            if (byte_cnt == BW'(0))
               tx_byte = base_q[15:8];
            else if (byte_cnt == BW'(1))
               tx_byte = base_q[7:0];
         end
         default: tx_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clk) begin
      if (accept)
         base_q <= flash_base;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= IDLE;
         run      <= 1'b0;
         spi_cs_n <= 1'b1;
         busy     <= 1'b0;
         done     <= 1'b0;
         byte_cnt <= '0;
      end else begin
         done <= 1'b0;
         case (state)
            IDLE: begin
               if (start) begin
                  state    <= CMD;
                  run      <= 1'b1;
                  spi_cs_n <= 1'b0; // Frame opens with busy
                  busy     <= 1'b1;
                  byte_cnt <= '0;
               end
            end
            CMD: begin
               if (byte_tick)
                  state <= ADDR;
            end
            ADDR: begin
               if (byte_tick) begin
                  if (byte_cnt == BW'(2)) begin
                     state    <= DATA;
                     byte_cnt <= '0;
                  end else begin
                     byte_cnt <= byte_cnt + BW'(1);
                  end
               end
            end
            DATA: begin
               if (byte_tick) begin
                  if (last_byte) begin
                     state <= FINISH;
                     run   <= 1'b0;
                  end else begin
                     byte_cnt <= byte_cnt + BW'(1);
                  end
               end
            end
            FINISH: begin
               // Last word lands in RAM this cycle
               state    <= IDLE;
               spi_cs_n <= 1'b1; // Frame closes after the last SCK rise
               done     <= 1'b1;
               busy     <= 1'b0;
            end
            default: state <= IDLE;
         endcase
      end
   end

   a_done_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> spi_cs_n);

endmodule

`default_nettype wire

// ==== hdl/flash_boot_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module flash_boot_top import boot_pkg::*; (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              start,
   input  wire flash_addr_t flash_base,
   input  wire              spi_miso,
   input  wire ram_addr_t   rd_addr,
   output logic             spi_sck,
   output logic             spi_cs_n,
   output logic             spi_mosi,
   output logic             busy,
   output logic             done,
   output word_t            rd_data
);

   wire            run;
   wire            fall_tick;
   wire            rise_tick;
   wire            byte_tick;
   wire            load;
   wire            take;
   wire            clear;
   wire byte_t     tx_byte;
   wire byte_t     rx_byte;
   wire            wr_en;
   wire ram_addr_t wr_addr;
   wire word_t     wr_data;

   boot_fsm boot_fsm_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .flash_base (flash_base),
      .byte_tick  (byte_tick),
      .run        (run),
      .spi_cs_n   (spi_cs_n),
      .load       (load),
      .tx_byte    (tx_byte),
      .take       (take),
      .clear      (clear),
      .busy       (busy),
      .done       (done)
   );

   sck_timer sck_timer_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .spi_sck   (spi_sck),
      .fall_tick (fall_tick),
      .rise_tick (rise_tick),
      .byte_tick (byte_tick)
   );

   spi_shifter spi_shifter_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .load      (load),
      .tx_byte   (tx_byte),
      .fall_tick (fall_tick),
      .rise_tick (rise_tick),
      .spi_miso  (spi_miso),
      .spi_mosi  (spi_mosi),
      .rx_byte   (rx_byte)
   );

   word_assembler word_assembler_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .clear   (clear),
      .take    (take),
      .rx_byte (rx_byte),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

   boot_ram boot_ram_i (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// ==== verification/spi_flash_model.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "boot_defines.svh"

module spi_flash_model import boot_pkg::*; (
   input  wire         spi_sck,
   input  wire         spi_cs_n,
   input  wire         spi_mosi,
   output logic        spi_miso,
   output byte_t       cmd_seen,
   output flash_addr_t addr_seen,
   output int          frames,
   output int          rises
);

   byte_t       mem [65536];    // 64 KiB with wrapping addresses
   logic [31:0] header = '0;    // Opcode and address as shifted in
   byte_t       cmd_q = '0;
   flash_addr_t addr_q = '0;
   int          frame_cnt = 0;
   int          cur_frame = -1;
   int          rise_cnt = 0;   // Rising edges in the current frame
   int          data_bit;
   logic [15:0] rd_ptr;
   logic        miso_q = 1'b0;

   assign spi_miso  = miso_q;
   assign cmd_seen  = cmd_q;
   assign addr_seen = addr_q;
   assign frames    = frame_cnt;
   assign rises     = rise_cnt;

   always @(negedge spi_cs_n) begin
      frame_cnt = frame_cnt + 1;
   end

   // Mode 0 with MOSI sampled on the rising edge
   always @(posedge spi_sck) begin
      if (!spi_cs_n) begin
         if (cur_frame != frame_cnt) begin
            cur_frame = frame_cnt; // First edge of a new frame
            rise_cnt  = 0;
         end
         if (rise_cnt < 32)
            header = {header[30:0], spi_mosi};
         rise_cnt = rise_cnt + 1;
         if (rise_cnt == 8)
            cmd_q = header[7:0];
         if (rise_cnt == 32)
            addr_q = header[23:0];
      end
   end

   // Data goes out MSB first once the address is complete
   always @(negedge spi_sck) begin
      if (!spi_cs_n && rise_cnt >= 32 && cmd_q == `FLASH_READ_CMD) begin
         data_bit = rise_cnt - 32;
         rd_ptr   = addr_q[15:0] + 16'(data_bit / 8);
         miso_q  <= mem[rd_ptr][3'(7 - data_bit % 8)];
      end
   end

endmodule

`default_nettype wire

// ==== verification/tb_flash_boot.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "boot_defines.svh"

module tb_flash_boot import boot_pkg::*; ();

   localparam int BOOTS        = 3;
   localparam int RESET_CYCLES = 16;
   localparam int FRAME_RISES  = 32 + 32 * `BOOT_WORDS;
   localparam int BOOT_CYCLES  = 64 * FRAME_RISES * `SCK_HALF / 32;
   localparam int READBACK     = 2 * `BOOT_WORDS + 64;
   localparam int CYCLE_LIMIT  = (RESET_CYCLES + BOOTS * (BOOT_CYCLES + READBACK)) * 2;

   logic        clk;
   logic        rst_n;
   logic        start;
   flash_addr_t flash_base;
   ram_addr_t   rd_addr;
   word_t       rd_data;
   logic        busy;
   logic        done;
   wire         spi_sck;
   wire         spi_cs_n;
   wire         spi_mosi;
   wire         spi_miso;
   byte_t       cmd_seen;
   flash_addr_t addr_seen;
   int          frames;
   int          rises;

   byte_t       image [65536]; // Copy of the flash contents for the reference model
   logic [31:0] lfsr;
   int          cycles = 0;
   int          done_count;

   flash_boot_top flash_boot_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .flash_base (flash_base),
      .spi_miso   (spi_miso),
      .rd_addr    (rd_addr),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .busy       (busy),
      .done       (done),
      .rd_data    (rd_data)
   );

   spi_flash_model flash_model_i (
      .spi_sck   (spi_sck),
      .spi_cs_n  (spi_cs_n),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso),
      .cmd_seen  (cmd_seen),
      .addr_seen (addr_seen),
      .frames    (frames),
      .rises     (rises)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
         abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
      if (actual !== expected)
         abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic check_addr(input string name, input flash_addr_t expected,
                             input flash_addr_t actual);
      if (actual !== expected)
         abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic check_level(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         abort_run($sformatf("** Error %s: expected %b, actual %b", name, expected, actual));
   endtask

   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h80200003;
      return n;
   endfunction

   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < count; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic fill_flash();
      byte_t b;
      for (int a = 0; a < 65536; a++) begin
         b                  = byte_t'(random_bits(8));
         image[a]           = b;
         flash_model_i.mem[a] = b;
      end
   endtask

   // Little endian with the first flash byte in lane 0
   function automatic word_t expected_word(input flash_addr_t base, input int index);
      logic [15:0] a;
      word_t       w;
      for (int k = 0; k < 4; k++) begin
         a            = base[15:0] + 16'(4 * index + k);
         w[8*k +: 8]  = image[a];
      end
      return w;
   endfunction

   task automatic run_boot(input int n);
      flash_addr_t base;
      int          frames_before;
      int          done_before;
      int          waited;
      base          = flash_addr_t'(random_bits(24));
      frames_before = frames;
      done_before   = done_count;
      @(negedge clk);
      check_level("busy before start", 1'b0, busy);
      flash_base = base;
      start      = 1'b1;
      @(negedge clk);
      start      = 1'b0;
      flash_base = '0; // Base must have been captured already
      check_level("busy after start", 1'b1, busy);
      check_level("cs_n after start", 1'b0, spi_cs_n);
      waited = 0;
      while (!done) begin
         check_level("busy during frame", 1'b1, busy);
         start = (waited == 100); // Extra start while busy is ignored
         @(negedge clk);
         waited++;
      end
      start = 1'b0;
      check_level("busy with done", 1'b0, busy);
      check_level("cs_n with done", 1'b1, spi_cs_n);
      repeat (20) @(negedge clk);
      if (done_count != done_before + 1)
         abort_run($sformatf("** Error boot %0d done pulses: expected 1, actual %0d",
                             n, done_count - done_before));
      if (frames != frames_before + 1)
         abort_run($sformatf("** Error boot %0d frames: expected 1, actual %0d",
                             n, frames - frames_before));
      if (rises != FRAME_RISES)
         abort_run($sformatf("** Error boot %0d sck rises: expected %0d, actual %0d",
                             n, FRAME_RISES, rises));
      check_byte("read opcode", `FLASH_READ_CMD, cmd_seen);
      check_addr("flash address", base, addr_seen);
      check_level("sck idle", 1'b0, spi_sck);
      // Pipelined readback with data one cycle behind the address
      for (int a = 0; a <= `BOOT_WORDS; a++) begin
         if (a > 0)
            check_word($sformatf("boot %0d word %0d", n, a - 1),
                       expected_word(base, a - 1), rd_data);
         if (a < `BOOT_WORDS)
            rd_addr = ram_addr_t'(a);
         @(negedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (!rst_n)
         done_count <= 0;
      else if (done)
         done_count <= done_count + 1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
         abort_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
   end

   initial begin
      rst_n      = 1'b0;
      start      = 1'b0;
      flash_base = '0;
      rd_addr    = '0;
      lfsr       = 32'h5d6c3f7b;
      fill_flash();
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_level("cs_n after reset", 1'b1, spi_cs_n);
      check_level("sck after reset", 1'b0, spi_sck);
      check_level("busy after reset", 1'b0, busy);
      check_level("done after reset", 1'b0, done);
      for (int n = 0; n < BOOTS; n++)
         run_boot(n);
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hdl/boot_pkg.sv
hdl/sck_timer.sv
hdl/spi_shifter.sv
hdl/word_assembler.sv
hdl/boot_ram.sv
hdl/boot_fsm.sv
hdl/flash_boot_top.sv
verification/spi_flash_model.sv
verification/tb_flash_boot.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_flash_boot

out=$(./obj_dir/Vtb_flash_boot 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1
